// ==== hdl/bypassNetwork.sv ====
// Operand forwarding from the registered execute result and one older writeback entry
module bypassNetwork (
    input logic clk,
    input logic arstN,
    input logic [4:0] addr1,
    input logic [4:0] addr2,
    input execTypes::word_t regValue1,
    input execTypes::word_t regValue2,
    input execTypes::fwdEntry_t exFwd,
    input logic advance,
    output execTypes::word_t operand1,
    output execTypes::word_t operand2
);
    import execTypes::*;

    fwdEntry_t wbFwd;
    logic exHit1;
    logic exHit2;
    logic wbHit1;
    logic wbHit2;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbFwd <= '0;
        end else if (advance) begin
            wbFwd <= exFwd;
        end
    end

    // x0 is hardwired, never forwarded
    assign exHit1 = exFwd.writeEnable && (exFwd.addr == addr1) && (addr1 != 5'd0);
    assign exHit2 = exFwd.writeEnable && (exFwd.addr == addr2) && (addr2 != 5'd0);
    assign wbHit1 = wbFwd.writeEnable && (wbFwd.addr == addr1) && (addr1 != 5'd0);
    assign wbHit2 = wbFwd.writeEnable && (wbFwd.addr == addr2) && (addr2 != 5'd0);

    // younger entry wins
    always_comb begin
        if (exHit1) begin
            operand1 = exFwd.value;
        end else if (wbHit1) begin
            operand1 = wbFwd.value;
        end else begin
            operand1 = regValue1;
        end

        if (exHit2) begin
            operand2 = exFwd.value;
        end else if (wbHit2) begin
            operand2 = wbFwd.value;
        end else begin
            operand2 = regValue2;
        end
    end

endmodule

// ==== hdl/execTypes.sv ====
// Shared enums and packed structs of the execute stage; compile before any module that uses them
`include "exec_config.svh"

package execTypes;

    typedef logic [`XLEN-1:0] word_t;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd,
        AluClear1,
        AluClear2
    } aluCommand_e;

    typedef enum logic [2:0] {
        BrEqual,
        BrNotEqual,
        BrLessThan,
        BrGreaterEqual,
        BrUnsignedLessThan,
        BrUnsignedGreaterEqual,
        BrAlways
    } branchType_e;

    typedef enum logic [2:0] {
        MdMul,
        MdMulh,
        MdMulhu,
        MdDiv,
        MdDivu,
        MdRem,
        MdRemu
    } mulDivType_e;

    typedef enum logic {UnitAlu, UnitMulDiv} exUnit_e;
    typedef enum logic [1:0] {Src1Zero, Src1Pc, Src1Reg} src1Sel_e;
    typedef enum logic [1:0] {Src2Zero, Src2Imm, Src2Reg} src2Sel_e;
    typedef enum logic {DstResult, DstNextPc} dstSel_e;
    typedef enum logic [1:0] {TrapNone, TrapEcall, TrapEbreak} trapOp_e;

    // RISC-V exception codes
    typedef enum logic [3:0] {
        CauseNone = 4'd0,
        CauseBreakpoint = 4'd3,
        CauseEcallFromMachine = 4'd11
    } trapCause_e;

    typedef struct packed {
        logic valid;
        exUnit_e unit;
        aluCommand_e aluCmd;
        branchType_e branchType;
        mulDivType_e mulDivType;
        logic isBranch;
        src1Sel_e src1Sel;
        src2Sel_e src2Sel;
        dstSel_e dstSel;
        logic regWrite;
        trapOp_e trapOp;
        word_t imm;
        word_t pc;
        logic [4:0] srcRegAddr1;
        logic [4:0] srcRegAddr2;
        logic [4:0] dstRegAddr;
        word_t srcValue1;
        word_t srcValue2;
    } execOp_t;

    typedef struct packed {
        logic valid;
        logic regWrite;
        logic [4:0] dstRegAddr;
        word_t dstValue;
        logic branchTaken;
        word_t branchTarget;
        logic trapValid;
        trapCause_e trapCause;
        word_t pc;
    } execResult_t;

    typedef struct packed {
        logic writeEnable;
        logic [4:0] addr;
        word_t value;
    } fwdEntry_t;

endpackage

// ==== hdl/execUnitTop.sv ====
// Top level of the execute subsystem; the pipeline controller or testbench drives issue
module execUnitTop (
    input logic clk,
    input logic arstN,
    input execTypes::execOp_t issue,
    output execTypes::execResult_t result,
    output logic stallReq,
    output logic flushReq,
    output execTypes::word_t nextPc
);

    // ALU, mul/div and bypass all live under the stage
    executeStage u_executeStage (
        .clk(clk),
        .arstN(arstN),
        .op(issue),
        .result(result),
        .stallReq(stallReq),
        .flushReq(flushReq),
        .nextPc(nextPc)
    );

endmodule

// ==== hdl/exec_config.svh ====
// Sizing macros for the execute stage; include wherever widths or step counts are needed
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// data path width and its log2
`define XLEN 32
`define XLEN_LOG2 5

// one iteration per operand bit in the mul/div unit
`define MULDIV_STEPS 32

// byte size of one instruction, used for the link value and fall-through pc
`define INSN_SIZE 4

`endif

// ==== hdl/executeStage.sv ====
// Integer execute stage with operand select, unit select, traps, next pc and the result register
`include "exec_config.svh"

module executeStage (
    input logic clk,
    input logic arstN,
    input execTypes::execOp_t op,
    output execTypes::execResult_t result,
    output logic stallReq,
    output logic flushReq,
    output execTypes::word_t nextPc
);
    import execTypes::*;

    word_t operand1;
    word_t operand2;
    word_t aluSrc1;
    word_t aluSrc2;
    word_t aluOut;
    logic condTrue;
    word_t mdValue;
    logic mdBusy;
    logic mdDone;
    logic mdStart;
    logic isMulDiv;
    word_t pcPlusInsn;
    word_t unitResult;
    word_t dstValue;
    logic branchTaken;
    logic trapValid;
    trapCause_e trapCause;
    execResult_t resultNext;
    fwdEntry_t exFwd;

    bypassNetwork u_bypassNetwork (
        .clk(clk),
        .arstN(arstN),
        .addr1(op.srcRegAddr1),
        .addr2(op.srcRegAddr2),
        .regValue1(op.srcValue1),
        .regValue2(op.srcValue2),
        .exFwd(exFwd),
        .advance(result.valid),
        .operand1(operand1),
        .operand2(operand2)
    );

    intAlu u_intAlu (
        .cmd(op.aluCmd),
        .branchType(op.branchType),
        .src1(aluSrc1),
        .src2(aluSrc2),
        .cmpSrc1(operand1),
        .cmpSrc2(operand2),
        .aluOut(aluOut),
        .condTrue(condTrue)
    );

    mulDivUnit u_mulDivUnit (
        .clk(clk),
        .arstN(arstN),
        .start(mdStart),
        .mulDivType(op.mulDivType),
        .src1(operand1),
        .src2(operand2),
        .busy(mdBusy),
        .done(mdDone),
        .value(mdValue)
    );

    always_comb begin
        case (op.src1Sel)
            Src1Pc: aluSrc1 = op.pc;
            Src1Reg: aluSrc1 = operand1;
            default: aluSrc1 = '0;
        endcase

        case (op.src2Sel)
            Src2Imm: aluSrc2 = op.imm;
            Src2Reg: aluSrc2 = operand2;
            default: aluSrc2 = '0;
        endcase
    end

    // mul/div holds the stage until done; the done cycle must not restart it
    assign isMulDiv = op.valid && (op.unit == UnitMulDiv);
    assign mdStart = isMulDiv && !mdBusy && !mdDone;
    assign stallReq = isMulDiv && !mdDone;

    assign pcPlusInsn = op.pc + word_t'(`INSN_SIZE);
    assign unitResult = (op.unit == UnitMulDiv) ? mdValue : aluOut;
    assign dstValue = (op.dstSel == DstNextPc) ? pcPlusInsn : unitResult;
    assign branchTaken = op.valid && op.isBranch && condTrue;

    always_comb begin
        case (op.trapOp)
            TrapEcall: trapCause = CauseEcallFromMachine;
            TrapEbreak: trapCause = CauseBreakpoint;
            default: trapCause = CauseNone;
        endcase
    end

    assign trapValid = op.valid && (op.trapOp != TrapNone);

    assign flushReq = op.valid && !stallReq && (branchTaken || trapValid);
    // branch target comes out of the ALU adder
    assign nextPc = branchTaken ? aluOut : pcPlusInsn;

    always_comb begin
        resultNext.valid = op.valid;
        resultNext.regWrite = op.valid && op.regWrite && !trapValid;
        resultNext.dstRegAddr = op.dstRegAddr;
        resultNext.dstValue = dstValue;
        resultNext.branchTaken = branchTaken;
        resultNext.branchTarget = aluOut;
        resultNext.trapValid = trapValid;
        resultNext.trapCause = trapCause;
        resultNext.pc = op.pc;
    end

    // a stalled cycle leaves a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else if (stallReq) begin
            result <= '0;
        end else begin
            result <= resultNext;
        end
    end

    // youngest completed op; it moves to the writeback slot when replaced
    always_comb begin
        exFwd.writeEnable = result.valid && result.regWrite;
        exFwd.addr = result.dstRegAddr;
        exFwd.value = result.dstValue;
    end

endmodule

// ==== hdl/intAlu.sv ====
// Combinational integer ALU and branch comparator, used inside the execute stage
`include "exec_config.svh"

module intAlu (
    input execTypes::aluCommand_e cmd,
    input execTypes::branchType_e branchType,
    input execTypes::word_t src1,
    input execTypes::word_t src2,
    input execTypes::word_t cmpSrc1,
    input execTypes::word_t cmpSrc2,
    output execTypes::word_t aluOut,
    output logic condTrue
);
    import execTypes::*;

    logic [`XLEN_LOG2-1:0] shamt;

    assign shamt = src2[`XLEN_LOG2-1:0];

    always_comb begin
        case (cmd)
            AluAdd: aluOut = src1 + src2;
            AluSub: aluOut = src1 - src2;
            AluSll: aluOut = src1 << shamt;
            AluSlt: aluOut = word_t'($signed(src1) < $signed(src2));
            AluSltu: aluOut = word_t'(src1 < src2);
            AluXor: aluOut = src1 ^ src2;
            AluSrl: aluOut = src1 >> shamt;
            // sign fill
            AluSra: aluOut = word_t'($signed(src1) >>> shamt);
            AluOr: aluOut = src1 | src2;
            AluAnd: aluOut = src1 & src2;
            AluClear1: aluOut = src1 & ~src2;
            AluClear2: aluOut = ~src1 & src2;
            default: aluOut = '0;
        endcase
    end

    // comparison is always on the register operands, never the immediate
    always_comb begin
        case (branchType)
            BrEqual: condTrue = (cmpSrc1 == cmpSrc2);
            BrNotEqual: condTrue = (cmpSrc1 != cmpSrc2);
            BrLessThan: condTrue = ($signed(cmpSrc1) < $signed(cmpSrc2));
            BrGreaterEqual: condTrue = ($signed(cmpSrc1) >= $signed(cmpSrc2));
            BrUnsignedLessThan: condTrue = (cmpSrc1 < cmpSrc2);
            BrUnsignedGreaterEqual: condTrue = (cmpSrc1 >= cmpSrc2);
            BrAlways: condTrue = 1'b1;
            default: condTrue = 1'b0;
        endcase
    end

endmodule

// ==== hdl/mulDivUnit.sv ====
// Iterative shift-add multiplier and restoring divider, started and polled by the execute stage
`include "exec_config.svh"

module mulDivUnit (
    input logic clk,
    input logic arstN,
    input logic start,
    input execTypes::mulDivType_e mulDivType,
    input execTypes::word_t src1,
    input execTypes::word_t src2,
    output logic busy,
    output logic done,
    output execTypes::word_t value
);
    import execTypes::*;

    localparam int CountWidth = $clog2(`MULDIV_STEPS);
    localparam logic [CountWidth-1:0] LastStep = CountWidth'(`MULDIV_STEPS - 1);

    logic busyQ;
    logic doneQ;
    logic [CountWidth-1:0] countQ;
    mulDivType_e typeQ;
    word_t hiQ;
    word_t loQ;
    word_t operandQ;
    logic negProductQ;
    logic negQuotientQ;
    logic negRemainderQ;

    logic isMulQ;
    logic signedOp;
    logic negA;
    logic negB;
    word_t absA;
    word_t absB;
    logic [`XLEN:0] mulSum;
    logic [`XLEN:0] divShifted;
    logic [`XLEN:0] divDiff;
    logic [2*`XLEN-1:0] product;
    logic [2*`XLEN-1:0] signedProduct;
    word_t quotient;
    word_t remainder;

    // operand magnitudes and result signs, decided at start
    assign signedOp = (mulDivType == MdMulh) || (mulDivType == MdDiv) || (mulDivType == MdRem);
    assign negA = signedOp && src1[`XLEN-1];
    assign negB = signedOp && src2[`XLEN-1];
    assign absA = negA ? -src1 : src1;
    assign absB = negB ? -src2 : src2;

    assign isMulQ = (typeQ == MdMul) || (typeQ == MdMulh) || (typeQ == MdMulhu);

    // one multiply step
    assign mulSum = {1'b0, hiQ} + {1'b0, (loQ[0] ? operandQ : '0)};

    // one restoring divide step, bit XLEN of the difference is the borrow
    assign divShifted = {hiQ, loQ[`XLEN-1]};
    assign divDiff = divShifted - {1'b0, operandQ};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busyQ <= 1'b0;
            doneQ <= 1'b0;
            countQ <= '0;
        end else begin
            doneQ <= 1'b0;
            if (start && !busyQ) begin
                busyQ <= 1'b1;
                countQ <= '0;
            end else if (busyQ) begin
                countQ <= countQ + 1'b1;
                if (countQ == LastStep) begin
                    busyQ <= 1'b0;
                    doneQ <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busyQ) begin
            typeQ <= mulDivType;
            hiQ <= '0;
            loQ <= absA;
            operandQ <= absB;
            negProductQ <= negA ^ negB;
            // divide by zero keeps the all-ones quotient unsigned
            negQuotientQ <= (negA ^ negB) && (src2 != '0);
            negRemainderQ <= negA;
        end else if (busyQ) begin
            if (isMulQ) begin
                hiQ <= mulSum[`XLEN:1];
                loQ <= {mulSum[0], loQ[`XLEN-1:1]};
            end else if (!divDiff[`XLEN]) begin
                hiQ <= divDiff[`XLEN-1:0];
                loQ <= {loQ[`XLEN-2:0], 1'b1};
            end else begin
                hiQ <= divShifted[`XLEN-1:0];
                loQ <= {loQ[`XLEN-2:0], 1'b0};
            end
        end
    end

    assign product = {hiQ, loQ};
    assign signedProduct = negProductQ ? -product : product;
    assign quotient = negQuotientQ ? -loQ : loQ;
    assign remainder = negRemainderQ ? -hiQ : hiQ;

    // held until the next start
    always_comb begin
        case (typeQ)
            MdMul: value = signedProduct[`XLEN-1:0];
            MdMulh, MdMulhu: value = signedProduct[2*`XLEN-1:`XLEN];
            MdDiv, MdDivu: value = quotient;
            MdRem, MdRemu: value = remainder;
            default: value = '0;
        endcase
    end

    assign busy = busyQ;
    assign done = doneQ;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module execUnitTb -o execSim

output="$(./obj_dir/execSim)"
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
fi
exit 1

// ==== sources.f ====
+incdir+hdl
hdl/execTypes.sv
hdl/intAlu.sv
hdl/mulDivUnit.sv
hdl/bypassNetwork.sv
hdl/executeStage.sv
hdl/execUnitTop.sv
tests/execUnitTb.sv

// ==== tests/execUnitTb.sv ====
// Testbench for the execute subsystem; replays tests/execVectors.txt and checks each result
module execUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    import execTypes::*;

    localparam int StallTimeout = 200;
    localparam int FieldCount = 23;

    logic clk;
    logic arstN;
    execOp_t issue;
    execResult_t result;
    logic stallReq;
    logic flushReq;
    word_t nextPc;

    int errors;
    int opIndex;
    logic timedOut;
    // one parsed vector line, columns as in the vector file
    logic [31:0] fields [FieldCount];

    execUnitTop u_execUnitTop (
        .clk(clk),
        .arstN(arstN),
        .issue(issue),
        .result(result),
        .stallReq(stallReq),
        .flushReq(flushReq),
        .nextPc(nextPc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED: %s at op %0d: got %h, expected %h",
                     name, opIndex, actual, expected);
        end
    endtask

    function automatic execOp_t decodeOp();
        execOp_t op;
        op = '0;
        op.valid = 1'b1;
        op.unit = exUnit_e'(fields[0][0]);
        op.aluCmd = aluCommand_e'(fields[1][3:0]);
        op.branchType = branchType_e'(fields[2][2:0]);
        op.mulDivType = mulDivType_e'(fields[3][2:0]);
        op.isBranch = fields[4][0];
        op.src1Sel = src1Sel_e'(fields[5][1:0]);
        op.src2Sel = src2Sel_e'(fields[6][1:0]);
        op.dstSel = dstSel_e'(fields[7][0]);
        op.regWrite = fields[8][0];
        op.trapOp = trapOp_e'(fields[9][1:0]);
        op.imm = fields[10];
        op.pc = fields[11];
        op.srcRegAddr1 = fields[12][4:0];
        op.srcRegAddr2 = fields[13][4:0];
        op.dstRegAddr = fields[14][4:0];
        op.srcValue1 = fields[15];
        op.srcValue2 = fields[16];
        return op;
    endfunction

    // present one op, ride out any stall, then check the registered result
    task automatic runOp();
        int waited;
        logic expFlush;
        expFlush = fields[19][0] | fields[21][0];
        issue = decodeOp();
        #1;
        // only mul/div ops stall
        checkValue("stallReq", stallReq, fields[0]);
        waited = 0;
        while (stallReq && waited < StallTimeout) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (stallReq) begin
            errors++;
            timedOut = 1'b1;
            $display("op %0d: stallReq still high after %0d cycles", opIndex, StallTimeout);
        end else begin
            checkValue("flushReq", flushReq, expFlush);
            checkValue("nextPc", nextPc, fields[20]);
            @(posedge clk);
            #1;
            checkValue("result.valid", result.valid, 1);
            checkValue("result.regWrite", result.regWrite, fields[18]);
            checkValue("result.dstRegAddr", result.dstRegAddr, fields[14]);
            if (fields[18][0]) begin
                checkValue("result.dstValue", result.dstValue, fields[17]);
            end
            checkValue("result.branchTaken", result.branchTaken, fields[19]);
            // a taken branch carries its target, which is also the expected next pc
            if (fields[19][0]) begin
                checkValue("result.branchTarget", result.branchTarget, fields[20]);
            end
            checkValue("result.trapValid", result.trapValid, fields[21]);
            checkValue("result.trapCause", result.trapCause, fields[22]);
            checkValue("result.pc", result.pc, fields[11]);
        end
    endtask

    initial begin
        int fd;
        int count;
        int lineCount;
        logic [8*256-1:0] skipped;

        errors = 0;
        opIndex = 0;
        timedOut = 1'b0;
        arstN = 1'b0;
        issue = '0;
        repeat (10) @(posedge clk);
        #1;
        arstN = 1'b1;
        @(posedge clk);
        #1;
        checkValue("result.valid", result.valid, 0);
        checkValue("stallReq", stallReq, 0);
        checkValue("flushReq", flushReq, 0);

        fd = $fopen("tests/execVectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open tests/execVectors.txt");
        end else begin
            lineCount = 0;
            while (!$feof(fd) && !timedOut && lineCount < 1000) begin
                lineCount++;
                count = $fscanf(fd,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
                    fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
                    fields[12], fields[13], fields[14], fields[15], fields[16], fields[17],
                    fields[18], fields[19], fields[20], fields[21], fields[22]);
                if (count == FieldCount) begin
                    opIndex++;
                    runOp();
                end else if (count >= 0) begin
                    if (count > 0) begin
                        errors++;
                        $display("malformed vector line after op %0d", opIndex);
                    end
                    // rest of a comment or broken line
                    count = $fgets(skipped, fd);
                end
            end
            $fclose(fd);
        end
        issue = '0;

        if (opIndex == 0) begin
            errors++;
            $display("no vectors were run");
        end

        $display("%0d ops run, %0d errors", opIndex, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/execVectors.txt ====
# op: unit aluCmd brType mdType isBranch src1Sel src2Sel dstSel regWrite trapOp imm pc rs1 rs2 rd v1 v2
# expected: dstValue (checked when regWrite) regWrite branchTaken nextPc trapValid trapCause
0 0 0 0 0 2 1 0 1 0 00000005 00001000 02 00 01 00000010 00000000 00000015 1 0 00001004 0 0
0 1 0 0 0 2 2 0 1 0 00000000 00001004 03 04 05 00000100 00000001 000000ff 1 0 00001008 0 0
0 0 0 0 0 2 2 0 1 0 00000000 00001008 01 05 06 00000000 00000000 00000114 1 0 0000100c 0 0
0 2 0 0 0 2 1 0 1 0 00000024 0000100c 07 00 08 00000003 00000000 00000030 1 0 00001010 0 0
0 7 0 0 0 2 1 0 1 0 00000004 00001010 09 00 0a f0000000 00000000 ff000000 1 0 00001014 0 0
0 6 0 0 0 2 1 0 1 0 00000004 00001014 09 00 0b f0000000 00000000 0f000000 1 0 00001018 0 0
0 3 0 0 0 2 2 0 1 0 00000000 00001018 0a 0c 0d 00000000 00000001 00000001 1 0 0000101c 0 0
0 4 0 0 0 2 2 0 1 0 00000000 0000101c 0c 0e 0f ff000000 00000001 00000000 1 0 00001020 0 0
0 5 0 0 0 2 1 0 1 0 00ff00ff 00001020 10 00 10 0000ffff 00000000 00ffff00 1 0 00001024 0 0
0 8 0 0 0 2 2 0 1 0 00000000 00001024 11 12 11 f0f00000 0000000f f0f0000f 1 0 00001028 0 0
0 9 0 0 0 2 2 0 1 0 00000000 00001028 10 11 13 12345678 00000000 00f00000 1 0 0000102c 0 0
0 a 0 0 0 2 2 0 1 0 00000000 0000102c 14 15 14 ffff0000 0f0f0f0f f0f00000 1 0 00001030 0 0
0 b 0 0 0 2 2 0 1 0 00000000 00001030 16 17 00 ffff0000 0f0f0f0f 00000f0f 1 0 00001034 0 0
0 0 0 0 0 2 1 0 1 0 00000007 00001034 00 00 18 00000000 00000000 00000007 1 0 00001038 0 0
0 0 0 0 1 1 1 0 0 0 00000100 00001038 19 1a 00 00000005 00000005 00000000 0 1 00001138 0 0
0 0 1 0 1 1 1 0 0 0 00000100 0000103c 19 1a 00 00000005 00000005 00000000 0 0 00001040 0 0
0 0 2 0 1 1 1 0 0 0 fffffff0 00001040 19 1a 00 ffffffff 00000001 00000000 0 1 00001030 0 0
0 0 3 0 1 1 1 0 0 0 fffffff0 00001044 19 1a 00 ffffffff 00000001 00000000 0 0 00001048 0 0
0 0 4 0 1 1 1 0 0 0 00000020 00001048 19 1a 00 ffffffff 00000001 00000000 0 0 0000104c 0 0
0 0 5 0 1 1 1 0 0 0 00000020 0000104c 19 1a 00 ffffffff 00000001 00000000 0 1 0000106c 0 0
0 0 6 0 1 1 1 1 1 0 00000200 00001050 00 00 01 00000000 00000000 00001054 1 1 00001250 0 0
1 0 0 0 0 2 2 0 1 0 00000000 00001054 02 03 04 00000007 fffffffd ffffffeb 1 0 00001058 0 0
1 0 0 1 0 2 2 0 1 0 00000000 00001058 06 07 05 80000000 00000002 ffffffff 1 0 0000105c 0 0
1 0 0 2 0 2 2 0 1 0 00000000 0000105c 09 0a 08 ffffffff ffffffff fffffffe 1 0 00001060 0 0
1 0 0 3 0 2 2 0 1 0 00000000 00001060 0c 0d 0b ffffffec 00000003 fffffffa 1 0 00001064 0 0
1 0 0 5 0 2 2 0 1 0 00000000 00001064 0c 0d 0e ffffffec 00000003 fffffffe 1 0 00001068 0 0
1 0 0 4 0 2 2 0 1 0 00000000 00001068 10 11 0f 00000064 00000007 0000000e 1 0 0000106c 0 0
1 0 0 6 0 2 2 0 1 0 00000000 0000106c 10 11 12 00000064 00000007 00000002 1 0 00001070 0 0
1 0 0 3 0 2 2 0 1 0 00000000 00001070 1b 1c 13 00000005 00000000 ffffffff 1 0 00001074 0 0
1 0 0 5 0 2 2 0 1 0 00000000 00001074 1d 1c 15 fffffff6 00000000 fffffff6 1 0 00001078 0 0
1 0 0 3 0 2 2 0 1 0 00000000 00001078 1e 1f 16 80000000 ffffffff 80000000 1 0 0000107c 0 0
0 0 0 0 0 2 2 0 1 0 00000000 0000107c 16 15 17 00000000 00000000 7ffffff6 1 0 00001080 0 0
0 0 0 0 0 0 0 0 1 1 00000000 00001080 00 00 18 00000000 00000000 00000000 0 0 00001084 1 b
0 0 0 0 0 0 0 0 1 2 00000000 00001084 00 00 19 00000000 00000000 00000000 0 0 00001088 1 3
